/* common/layers_pkg.sv */
package layers_pkg;

    // sample and weight widths
    localparam int IMG_WIDTH = 16;
    localparam int KER_WIDTH = 16;

    // one guard bit above the full product width
    localparam int NUM_WIDTH = IMG_WIDTH + KER_WIDTH + 1;

    typedef logic signed [IMG_WIDTH-1:0] img_t;
    typedef logic signed [KER_WIDTH-1:0] ker_t;
    typedef logic signed [NUM_WIDTH-1:0] num_t;

    // configuration bus
    localparam int CFG_AWIDTH = 5;
    localparam int CFG_DWIDTH = 32;

    localparam logic [CFG_AWIDTH-1:0] CFG_LAYERS = 5'd2;

    typedef struct packed {
        logic [CFG_DWIDTH-1:0] data;
        logic [CFG_AWIDTH-1:0] addr;
        logic                  valid;
    } cfg_bus_t;

    // decoded from data[16], data[15:8] and data[7:0]
    typedef struct packed {
        logic       bypass;
        logic [7:0] pool_nb;
        logic [7:0] shift;
    } layer_cfg_t;

    // accumulation side
    typedef enum logic [1:0] {
        UP_RESET,
        UP_READY,
        UP_DONE,
        UP_CLEAR
    } up_state_e;

    // sum, pool and output side
    typedef enum logic [2:0] {
        DN_RESET,
        DN_READY,
        DN_ADD,
        DN_POOL,
        DN_OPS,
        DN_CLEAR
    } dn_state_e;

    // pipeline latencies in clock cycles
    localparam int MAC_LAT = 4;
    localparam int ADD_LAT = 2;
    localparam int OPS_LAT = 3;

endpackage

/* hdl/layer_ctrl.sv */
module layer_ctrl #(
    parameter int GROUP_NB = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  layers_pkg::cfg_bus_t                cfg,
    input  layers_pkg::img_t [GROUP_NB-1:0]     image_bus,
    input  logic                                image_val,
    input  logic                                image_last,
    input  logic                                result_rdy,
    output logic                                image_rdy,
    output logic                                kernel_rdy,
    output layers_pkg::img_t [GROUP_NB-1:0]     image_reg,
    output logic                                mac_clear,
    output logic                                mac_done,
    output logic                                add_start,
    output logic                                pool_first,
    output logic                                pool_load,
    output logic                                ops_start,
    output logic                                result_load,
    output layers_pkg::layer_cfg_t              layer_cfg,
    output logic                                result_val
);

    import layers_pkg::*;

    up_state_e up_state;
    up_state_e up_next;
    dn_state_e dn_state;
    dn_state_e dn_next;

    logic [2:0] mac_cnt;
    logic [2:0] add_cnt;
    logic [2:0] ops_cnt;
    logic [7:0] pool_cnt;

    logic accept;
    logic last_accept;
    logic pool_last;
    logic add_done;

    // load on start, then count down to zero; done is seen when the count is one
    function automatic logic [2:0] lat_next(input logic [2:0] cnt, input logic start,
                                            input logic [2:0] lat);
        if (start) begin
            return lat;
        end
        if (cnt != 3'd0) begin
            return cnt - 3'd1;
        end
        return cnt;
    endfunction

    assign accept      = image_val & image_rdy;
    assign last_accept = accept & image_last;

    assign image_rdy   = (up_state == UP_READY);
    assign mac_clear   = (up_state == UP_RESET);
    assign result_val  = (dn_state == DN_CLEAR);

    // handover from accumulation to the sum stage
    assign add_start   = (up_state == UP_CLEAR) && (dn_state == DN_READY);

    assign mac_done    = (mac_cnt == 3'd1);
    assign add_done    = (add_cnt == 3'd1);
    assign result_load = (ops_cnt == 3'd1);

    assign pool_load   = add_done;
    assign pool_first  = (pool_cnt == 8'd0);
    assign pool_last   = (pool_cnt >= layer_cfg.pool_nb);
    assign ops_start   = (dn_state == DN_POOL) && pool_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            layer_cfg <= '0;
        end else if (cfg.valid && (cfg.addr == CFG_LAYERS)) begin
            layer_cfg <= {cfg.data[16], cfg.data[15:8], cfg.data[7:0]};
        end
    end

    // image samples line up with the kernel_rdy pulse
    always_ff @(posedge clk) begin
        image_reg <= image_bus;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            kernel_rdy <= 1'b0;
        end else begin
            kernel_rdy <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mac_cnt <= 3'd0;
            add_cnt <= 3'd0;
            ops_cnt <= 3'd0;
        end else begin
            mac_cnt <= lat_next(mac_cnt, last_accept, 3'(MAC_LAT));
            add_cnt <= lat_next(add_cnt, add_start, 3'(ADD_LAT));
            ops_cnt <= lat_next(ops_cnt, ops_start, 3'(OPS_LAT));
        end
    end

    always_ff @(posedge clk) begin
        if (rst || (dn_state == DN_RESET)) begin
            pool_cnt <= 8'd0;
        end else if (dn_state == DN_POOL) begin
            pool_cnt <= pool_last ? 8'd0 : pool_cnt + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            up_state <= UP_RESET;
            dn_state <= DN_RESET;
        end else begin
            up_state <= up_next;
            dn_state <= dn_next;
        end
    end

    always_comb begin
        up_next = up_state;
        case (up_state)
            UP_RESET: up_next = UP_READY;
            UP_READY: if (last_accept) up_next = UP_DONE;
            UP_DONE:  if (mac_done) up_next = UP_CLEAR;
            // wait here until the sum stage is free
            UP_CLEAR: if (dn_state == DN_READY) up_next = UP_RESET;
            default:  up_next = UP_RESET;
        endcase
    end

    always_comb begin
        dn_next = dn_state;
        case (dn_state)
            DN_RESET: dn_next = DN_READY;
            DN_READY: if (up_state == UP_CLEAR) dn_next = DN_ADD;
            DN_ADD:   if (add_done) dn_next = DN_POOL;
            DN_POOL:  dn_next = pool_last ? DN_OPS : DN_READY;
            DN_OPS:   if (result_load) dn_next = DN_CLEAR;
            DN_CLEAR: if (result_rdy) dn_next = DN_RESET;
            default:  dn_next = DN_RESET;
        endcase
    end

endmodule

/* conv/filter_mac.sv */
module filter_mac #(
    parameter int GROUP_NB = 4
) (
    input  logic                                clk,
    input  layers_pkg::img_t [GROUP_NB-1:0]     image_reg,
    input  layers_pkg::ker_t [GROUP_NB-1:0]     kernel,
    input  logic                                kernel_rdy,
    input  logic                                mac_clear,
    input  logic                                add_start,
    output layers_pkg::num_t [GROUP_NB-1:0]     held
);

    import layers_pkg::*;

    num_t [GROUP_NB-1:0] prod;
    num_t [GROUP_NB-1:0] acc;
    logic                prod_val;

    // product stage flag, one cycle behind kernel_rdy
    always_ff @(posedge clk) begin
        if (mac_clear) begin
            prod_val <= 1'b0;
        end else begin
            prod_val <= kernel_rdy;
        end
    end

    always_ff @(posedge clk) begin
        if (kernel_rdy) begin
            for (int l = 0; l < GROUP_NB; l++) begin
                prod[l] <= $signed(image_reg[l]) * $signed(kernel[l]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mac_clear) begin
            acc <= '0;
        end else if (prod_val) begin
            for (int l = 0; l < GROUP_NB; l++) begin
                acc[l] <= acc[l] + prod[l];
            end
        end
    end

    // frees the accumulators for the next pass
    always_ff @(posedge clk) begin
        if (add_start) begin
            held <= acc;
        end
    end

endmodule

/* conv/lane_sum.sv */
module lane_sum #(
    parameter int GROUP_NB = 4
) (
    input  logic                                clk,
    input  layers_pkg::num_t [GROUP_NB-1:0]     held,
    output layers_pkg::num_t                    sum
);

    import layers_pkg::*;

    num_t total;

    // adder tree left to synthesis; wraps at NUM_WIDTH
    always_comb begin
        total = '0;
        for (int l = 0; l < GROUP_NB; l++) begin
            total = total + held[l];
        end
    end

    always_ff @(posedge clk) begin
        sum <= total;
    end

endmodule

/* post/filter_post.sv */
module filter_post (
    input  logic                    clk,
    input  layers_pkg::num_t        sum,
    input  layers_pkg::num_t        bias,
    input  layers_pkg::layer_cfg_t  layer_cfg,
    input  logic                    pool_first,
    input  logic                    pool_load,
    input  logic                    ops_start,
    input  logic                    result_load,
    output layers_pkg::img_t        result
);

    import layers_pkg::*;

    // signed limits of an image sample
    localparam num_t SAT_MAX = num_t'((2 ** (IMG_WIDTH - 1)) - 1);
    localparam num_t SAT_MIN = -num_t'(2 ** (IMG_WIDTH - 1));

    num_t pool_q;
    num_t bias_q;
    num_t relu_q;
    num_t shifted;
    img_t sat_q;

    // max pooling over successive passes
    always_ff @(posedge clk) begin
        if (pool_load) begin
            if (pool_first || (sum > pool_q)) begin
                pool_q <= sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ops_start) begin
            bias_q <= pool_q + bias;
        end
    end

    // relu, skipped when bypass is set
    always_ff @(posedge clk) begin
        if (!layer_cfg.bypass && bias_q[NUM_WIDTH-1]) begin
            relu_q <= '0;
        end else begin
            relu_q <= bias_q;
        end
    end

    assign shifted = relu_q >>> layer_cfg.shift;

    always_ff @(posedge clk) begin
        if (shifted > SAT_MAX) begin
            sat_q <= img_t'(SAT_MAX);
        end else if (shifted < SAT_MIN) begin
            sat_q <= img_t'(SAT_MIN);
        end else begin
            sat_q <= img_t'(shifted);
        end
    end

    // held steady while the result waits downstream
    always_ff @(posedge clk) begin
        if (result_load) begin
            result <= sat_q;
        end
    end

endmodule

/* hdl/layers_top.sv */
module layers_top #(
    parameter int DEPTH_NB = 4,
    parameter int GROUP_NB = 4
) (
    input  logic                                            clk,
    input  logic                                            rst,

    input  layers_pkg::cfg_bus_t                            cfg,

    input  layers_pkg::img_t [GROUP_NB-1:0]                 image_bus,
    input  logic                                            image_val,
    input  logic                                            image_last,
    output logic                                            image_rdy,

    input  layers_pkg::ker_t [DEPTH_NB-1:0][GROUP_NB-1:0]   kernel_bus,
    output logic                                            kernel_rdy,

    input  layers_pkg::num_t [DEPTH_NB-1:0]                 bias_bus,

    output layers_pkg::img_t [DEPTH_NB-1:0]                 result_bus,
    output logic                                            result_val,
    input  logic                                            result_rdy
);

    import layers_pkg::*;

    img_t [GROUP_NB-1:0] image_reg;
    layer_cfg_t          layer_cfg;

    logic mac_clear;
    logic mac_done;
    logic add_start;
    logic pool_first;
    logic pool_load;
    logic ops_start;
    logic result_load;

    layer_ctrl #(
        .GROUP_NB (GROUP_NB)
    ) ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .image_bus   (image_bus),
        .image_val   (image_val),
        .image_last  (image_last),
        .result_rdy  (result_rdy),
        .image_rdy   (image_rdy),
        .kernel_rdy  (kernel_rdy),
        .image_reg   (image_reg),
        .mac_clear   (mac_clear),
        .mac_done    (mac_done),
        .add_start   (add_start),
        .pool_first  (pool_first),
        .pool_load   (pool_load),
        .ops_start   (ops_start),
        .result_load (result_load),
        .layer_cfg   (layer_cfg),
        .result_val  (result_val)
    );

    // one datapath slice per filter
    for (genvar i = 0; i < DEPTH_NB; i++) begin : g_filter
        num_t [GROUP_NB-1:0] held;
        num_t                sum;

        filter_mac #(
            .GROUP_NB (GROUP_NB)
        ) mac_i (
            .clk        (clk),
            .image_reg  (image_reg),
            .kernel     (kernel_bus[i]),
            .kernel_rdy (kernel_rdy),
            .mac_clear  (mac_clear),
            .add_start  (add_start),
            .held       (held)
        );

        lane_sum #(
            .GROUP_NB (GROUP_NB)
        ) sum_i (
            .clk  (clk),
            .held (held),
            .sum  (sum)
        );

        filter_post post_i (
            .clk         (clk),
            .sum         (sum),
            .bias        (bias_bus[i]),
            .layer_cfg   (layer_cfg),
            .pool_first  (pool_first),
            .pool_load   (pool_load),
            .ops_start   (ops_start),
            .result_load (result_load),
            .result      (result_bus[i])
        );
    end

endmodule

/* test/layers_tb.sv */
module layers_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import layers_pkg::*;

    localparam int DEPTH_NB   = 4;
    localparam int GROUP_NB   = 4;
    localparam int BEATS      = 3;
    localparam int WAIT_LIMIT = 200;

    logic                              clk;
    logic                              rst;
    cfg_bus_t                          cfg;
    img_t [GROUP_NB-1:0]               image_bus;
    logic                              image_val;
    logic                              image_last;
    logic                              image_rdy;
    ker_t [DEPTH_NB-1:0][GROUP_NB-1:0] kernel_bus;
    logic                              kernel_rdy;
    num_t [DEPTH_NB-1:0]               bias_bus;
    img_t [DEPTH_NB-1:0]               result_bus;
    logic                              result_val;
    logic                              result_rdy;

    int          check_errors;
    int          assert_errors;
    int          timeouts;
    logic        cur_bypass;
    int          cur_shift;
    longint      pass_sum [DEPTH_NB];
    longint      pool_max [DEPTH_NB];
    img_t [DEPTH_NB-1:0] held_result;

    layers_top #(
        .DEPTH_NB (DEPTH_NB),
        .GROUP_NB (GROUP_NB)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .image_bus  (image_bus),
        .image_val  (image_val),
        .image_last (image_last),
        .image_rdy  (image_rdy),
        .kernel_bus (kernel_bus),
        .kernel_rdy (kernel_rdy),
        .bias_bus   (bias_bus),
        .result_bus (result_bus),
        .result_val (result_val),
        .result_rdy (result_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // one kernel_rdy pulse for each accepted beat, one cycle later
    kernel_follows: assert property (@(posedge clk) disable iff (rst)
        kernel_rdy == $past(image_val && image_rdy))
        else begin
            assert_errors++;
            $display("[FAIL] kernel_rdy expected %h got %h",
                     !$sampled(kernel_rdy), $sampled(kernel_rdy));
        end

    result_hold: assert property (@(posedge clk) disable iff (rst)
        (result_val && !result_rdy) |=> (result_val && $stable(result_bus)))
        else begin
            assert_errors++;
            $display("result_val or result_bus changed before the result was taken");
        end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic end_run();
        $display("errors: %0d checks, %0d assertions, %0d timeouts",
                 check_errors, assert_errors, timeouts);
        if (check_errors + assert_errors + timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected_value);
        assert (actual === expected_value) else begin
            check_errors++;
            $display("[FAIL] %s expected %h got %h", name, expected_value, actual);
        end
    endtask

    task automatic wait_image_rdy(input int limit);
        int count;
        count = 0;
        while (!image_rdy && count < limit) begin
            step();
            count++;
        end
        if (!image_rdy) begin
            timeouts++;
            $display("timeout: image_rdy stayed low for %0d cycles", limit);
            end_run();
        end
    endtask

    task automatic wait_result_val();
        int count;
        count = 0;
        while (!result_val && count < WAIT_LIMIT) begin
            step();
            count++;
        end
        if (!result_val) begin
            timeouts++;
            $display("timeout: no result after %0d cycles", WAIT_LIMIT);
            end_run();
        end
    endtask

    // uniform in -64..64, or a magnitude 1..64 with a forced sign
    function automatic int small_rand(input int sign_mode);
        int mag;
        mag = int'($urandom_range(64, 1));
        if (sign_mode == 1) begin
            return mag;
        end
        if (sign_mode == 2) begin
            return -mag;
        end
        return int'($urandom_range(128, 0)) - 64;
    endfunction

    function automatic longint model_result(input longint pooled, input longint bias);
        longint v;
        v = pooled + bias;
        if (!cur_bypass && v < 0) begin
            v = 0;
        end
        v = v >>> cur_shift;
        if (v > 32767) begin
            v = 32767;
        end
        if (v < -32768) begin
            v = -32768;
        end
        return v;
    endfunction

    task automatic write_cfg(input logic bypass, input logic [7:0] pool_nb,
                             input logic [7:0] shift);
        cfg.data  = {15'd0, bypass, pool_nb, shift};
        cfg.addr  = CFG_LAYERS;
        cfg.valid = 1'b1;
        step();
        cfg.valid  = 1'b0;
        cur_bypass = bypass;
        cur_shift  = shift;
    endtask

    task automatic set_bias(input int lo, input int hi);
        for (int f = 0; f < DEPTH_NB; f++) begin
            bias_bus[f] = num_t'(int'($urandom_range(hi - lo, 0)) + lo);
        end
    endtask

    // weights follow their beat into the kernel_rdy cycle
    task automatic send_pass(input int img_sign, input int ker_sign);
        img_t [GROUP_NB-1:0]               img;
        ker_t [DEPTH_NB-1:0][GROUP_NB-1:0] ker;
        for (int f = 0; f < DEPTH_NB; f++) begin
            pass_sum[f] = 0;
        end
        for (int b = 0; b < BEATS; b++) begin
            for (int l = 0; l < GROUP_NB; l++) begin
                img[l] = img_t'(small_rand(img_sign));
            end
            for (int f = 0; f < DEPTH_NB; f++) begin
                for (int l = 0; l < GROUP_NB; l++) begin
                    ker[f][l] = ker_t'(small_rand(ker_sign));
                    pass_sum[f] += longint'(img[l]) * longint'(ker[f][l]);
                end
            end
            image_bus  = img;
            image_val  = 1'b1;
            image_last = (b == BEATS - 1);
            wait_image_rdy(WAIT_LIMIT);
            step();
            kernel_bus = ker;
        end
        image_val  = 1'b0;
        image_last = 1'b0;
    endtask

    task automatic run_set(input int passes, input int img_sign, input int ker_sign);
        for (int p = 0; p < passes; p++) begin
            send_pass(img_sign, ker_sign);
            for (int f = 0; f < DEPTH_NB; f++) begin
                if (p == 0 || pass_sum[f] > pool_max[f]) begin
                    pool_max[f] = pass_sum[f];
                end
            end
        end
    endtask

    task automatic check_results();
        longint exp_v;
        for (int f = 0; f < DEPTH_NB; f++) begin
            exp_v = model_result(pool_max[f], longint'(bias_bus[f]));
            check_value($sformatf("result_bus[%0d]", f), result_bus[f], 16'(exp_v));
        end
    endtask

    task automatic expect_result();
        wait_result_val();
        check_results();
        step();
        check_value("result_val", result_val, 16'd0);
    endtask

    initial begin
        void'($urandom(32'hf4f8));
        check_errors  = 0;
        assert_errors = 0;
        timeouts      = 0;
        cur_bypass    = 1'b0;
        cur_shift     = 0;
        rst        = 1'b1;
        cfg        = '0;
        image_bus  = '0;
        image_val  = 1'b0;
        image_last = 1'b0;
        kernel_bus = '0;
        bias_bus   = '0;
        result_rdy = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        check_value("kernel_rdy", kernel_rdy, 16'd0);
        check_value("result_val", result_val, 16'd0);
        wait_image_rdy(2);

        // plain passes
        write_cfg(1'b1, 8'd0, 8'd0);
        set_bias(-1000, 1000);
        for (int n = 0; n < 2; n++) begin
            run_set(1, 0, 0);
            expect_result();
        end

        // relu on negative, then positive sums
        write_cfg(1'b0, 8'd0, 8'd0);
        set_bias(-100, -1);
        run_set(1, 1, 2);
        expect_result();
        set_bias(0, 100);
        run_set(1, 1, 1);
        expect_result();

        // pooling over three passes with rescale, then both saturation limits
        write_cfg(1'b1, 8'd2, 8'd3);
        set_bias(-1000, 1000);
        run_set(3, 0, 0);
        expect_result();
        write_cfg(1'b1, 8'd2, 8'd1);
        set_bias(500000, 500000);
        run_set(3, 0, 0);
        expect_result();
        set_bias(-500000, -500000);
        run_set(3, 0, 0);
        expect_result();

        // back-pressure while the next pass accumulates
        write_cfg(1'b1, 8'd0, 8'd0);
        set_bias(-1000, 1000);
        result_rdy = 1'b0;
        run_set(1, 0, 0);
        wait_result_val();
        check_results();
        for (int f = 0; f < DEPTH_NB; f++) begin
            held_result[f] = img_t'(model_result(pool_max[f], longint'(bias_bus[f])));
        end
        run_set(1, 0, 0);
        repeat (12) step();
        check_value("result_val", result_val, 16'd1);
        for (int f = 0; f < DEPTH_NB; f++) begin
            check_value($sformatf("result_bus[%0d] held", f), result_bus[f], held_result[f]);
        end
        result_rdy = 1'b1;
        step();
        expect_result();

        repeat (4) step();
        end_run();
    end

endmodule

/* sources.f */
common/layers_pkg.sv
hdl/layer_ctrl.sv
conv/filter_mac.sv
conv/lane_sum.sv
post/filter_post.sv
hdl/layers_top.sv
test/layers_tb.sv
